//--- list.f
+incdir+include
hw/fp_slice_pkg.sv
hw/fp_slice_operand_split.sv
hw/fp_slice_pipe.sv
hw/fp_slice_lane.sv
hw/fp_slice_result_pack.sv
hw/fp_slice_top.sv
bench/fp_slice_assert.sv
bench/fp_slice_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f list.f --top-module fp_slice_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vfp_slice_tb)"; echo "$$out"; \
	  echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

//--- bench/fp_slice_tb.sv
// Self-checking testbench for the FP slice; compile with list.f and run fp_slice_tb as top
`timescale 1ns/10ps
`include "slice_defs.svh"

module fp_slice_tb import fp_slice_pkg::*; ();

  localparam int TIMEOUT  = 200;
  localparam int N_RANDOM = 80;

  logic        clk_i;
  logic        rst_i;
  slice_req_t  req_i;
  logic        in_valid_i;
  logic        in_ready_o;
  slice_rsp_t  rsp_o;
  logic        out_valid_o;
  logic        out_ready_i;
  logic        busy_o;

  logic [31:0] lfsr_q;
  logic        bp_en;
  int          sent = 0;
  int          received = 0;
  slice_rsp_t  exp_q[$];

  fp_slice_top DUT (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic next_cycle();
    logic [31:0] r;
    @(posedge clk_i);
    #1;
    if (bp_en) begin
      draw(2, r);
      // Sink ready about three cycles out of four
      out_ready_i = |r[1:0];
    end
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  // Elements are left-aligned so that one ordering key serves both formats
  function automatic logic [31:0] elem_ref(input logic wide, input logic [31:0] a,
                                           input logic [31:0] b, input op_e op,
                                           output logic nv);
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] kx;
    logic [31:0] ky;
    logic [31:0] res;
    logic        nan_x;
    logic        nan_y;
    int          shift;
    shift = wide ? 0 : 16;
    x = a << shift;
    y = b << shift;
    nan_x = wide ? (x[30:23] == 8'hFF && x[22:0] != 0) : (x[30:26] == 5'h1F && x[25:16] != 0);
    nan_y = wide ? (y[30:23] == 8'hFF && y[22:0] != 0) : (y[30:26] == 5'h1F && y[25:16] != 0);
    kx = x[31] ? ~x : (x | 32'h8000_0000);
    ky = y[31] ? ~y : (y | 32'h8000_0000);
    nv = 1'b0;
    case (op)
      OP_SGNJ:  res = {y[31], x[30:0]};
      OP_SGNJN: res = {~y[31], x[30:0]};
      OP_SGNJX: res = {x[31] ^ y[31], x[30:0]};
      default: begin
        nv = (nan_x && !(wide ? x[22] : x[25])) || (nan_y && !(wide ? y[22] : y[25]));
        if (nan_x && nan_y) res = wide ? 32'h7FC0_0000 : 32'h7E00_0000;
        else if (nan_x) res = y;
        else if (nan_y) res = x;
        else if ((op == OP_MIN) == (kx < ky)) res = x;
        else res = y;
      end
    endcase
    return res >> shift;
  endfunction

  function automatic slice_rsp_t rsp_ref(input slice_req_t req);
    slice_rsp_t  rsp;
    logic [31:0] r0;
    logic [31:0] r1;
    logic        nv0;
    logic        nv1;
    r0 = elem_ref(req.fmt == FMT_FP32, req.operand_a, req.operand_b, req.op, nv0);
    r1 = elem_ref(1'b0, req.operand_a >> 16, req.operand_b >> 16, req.op, nv1);
    rsp = '0;
    rsp.tag = req.tag;
    rsp.status.nv = nv0 & req.simd_mask[0];
    if (req.fmt == FMT_FP32) begin
      rsp.result = r0;
    end else if (req.vectorial) begin
      rsp.result = {r1[15:0], r0[15:0]};
      rsp.status.nv = rsp.status.nv | (nv1 & req.simd_mask[1]);
    end else begin
      rsp.result = {16'hFFFF, r0[15:0]};
    end
    return rsp;
  endfunction

  // ------------------------------
  // Stimulus
  // ------------------------------
  function automatic slice_req_t make_req(input logic [31:0] a, input logic [31:0] b,
                                          input op_e op, input fmt_e fmt, input logic vec,
                                          input logic [1:0] mask, input logic [7:0] tag);
    slice_req_t req;
    req = '{operand_a: a, operand_b: b, op: op, fmt: fmt, vectorial: vec,
            simd_mask: mask, tag: tag};
    return req;
  endfunction

  // Biased toward quiet NaN, signaling NaN and signed zero
  task automatic rand_elem(input logic wide, output logic [31:0] e);
    logic [31:0] sel;
    logic [31:0] r;
    draw(3, sel);
    draw(32, r);
    case (sel[2:0])
      3'd0:    e = wide ? {r[31], 9'h1FF, r[21:0]} : {16'h0, r[15], 6'h3F, r[8:0]};
      3'd1:    e = wide ? {r[31], 8'hFF, 1'b0, r[21:1], 1'b1}
                        : {16'h0, r[15], 5'h1F, 1'b0, r[8:1], 1'b1};
      3'd2:    e = wide ? {r[31], 31'h0} : {16'h0, r[15], 15'h0};
      default: e = wide ? r : {16'h0, r[15:0]};
    endcase
  endtask

  task automatic rand_req(input logic [7:0] tag, output slice_req_t req);
    logic [31:0] r;
    logic [31:0] lo;
    logic [31:0] hi;
    draw(3, r);
    req.op = op_e'(3'(r % 32'd5));
    draw(4, r);
    req.fmt       = fmt_e'(r[0]);
    req.vectorial = r[1];
    req.simd_mask = r[3:2];
    req.tag       = tag;
    rand_elem(req.fmt == FMT_FP32, lo);
    rand_elem(1'b0, hi);
    req.operand_a = (req.fmt == FMT_FP32) ? lo : {hi[15:0], lo[15:0]};
    rand_elem(req.fmt == FMT_FP32, lo);
    rand_elem(1'b0, hi);
    req.operand_b = (req.fmt == FMT_FP32) ? lo : {hi[15:0], lo[15:0]};
  endtask

  task automatic send(input slice_req_t req);
    int   waited;
    logic taken;
    req_i      = req;
    in_valid_i = 1'b1;
    waited     = 0;
    taken      = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = in_ready_o;
      next_cycle();
      waited++;
      if (!taken && waited > TIMEOUT) begin
        fail_run("Timed out waiting for the slice to take a request");
      end
    end
    in_valid_i = 1'b0;
    sent++;
  endtask

  // Only the pipeline state decides when traffic is over
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (busy_o) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) fail_run("Timed out waiting for the pipeline to drain");
    end
  endtask

  task automatic latency_test(input slice_req_t req);
    int cycles;
    send(req);
    // Send returns just after the accepting edge
    cycles = 1;
    @(negedge clk_i);
    while (!out_valid_o) begin
      next_cycle();
      cycles++;
      if (cycles > TIMEOUT) fail_run("Timed out waiting for a response");
      @(negedge clk_i);
    end
    check("latency", 64'(`SLICE_PIPE_REGS), 64'(cycles));
    wait_drain();
  endtask

  // Transfers are judged at the falling edge, where handshake signals are settled
  always @(negedge clk_i) begin : scoreboard
    if (!rst_i && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        fail_run("A response arrived with no request outstanding");
      end else begin
        check("rsp_o", 64'(exp_q[0]), 64'(rsp_o));
        void'(exp_q.pop_front());
        received++;
      end
    end
    if (!rst_i && in_valid_i && in_ready_o) begin
      exp_q.push_back(rsp_ref(req_i));
    end
  end

  initial begin : stimulus
    slice_req_t req;
    lfsr_q      = 32'd81405;
    bp_en       = 1'b0;
    rst_i       = 1'b1;
    req_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(negedge clk_i);
    check("out_valid_o", 64'(0), 64'(out_valid_o));
    check("busy_o", 64'(0), 64'(busy_o));
    check("in_ready_o", 64'(1), 64'(in_ready_o));
    next_cycle();

    latency_test(make_req(32'h3F80_0000, 32'hC000_0000, OP_SGNJ, FMT_FP32, 1'b0, 2'b01, 8'h01));
    latency_test(make_req(32'h8000_7E00, 32'h0000_7D00, OP_MAX, FMT_FP16, 1'b1, 2'b10, 8'h02));
    send(make_req(32'h4049_0FDB, 32'h3F80_0000, OP_SGNJN, FMT_FP32, 1'b0, 2'b11, 8'h03));
    send(make_req(32'hC000_0000, 32'hBF80_0000, OP_SGNJX, FMT_FP32, 1'b0, 2'b11, 8'h04));
    send(make_req(32'h1234_7D00, 32'h5678_3C00, OP_MIN, FMT_FP16, 1'b0, 2'b01, 8'h05));
    send(make_req(32'h0000_0000, 32'h8000_0000, OP_MIN, FMT_FP32, 1'b0, 2'b01, 8'h06));
    send(make_req(32'h7FC0_0001, 32'h7F80_0001, OP_MAX, FMT_FP32, 1'b1, 2'b01, 8'h07));
    wait_drain();

    // Back-to-back random traffic against a stalling sink
    bp_en = 1'b1;
    for (int i = 0; i < N_RANDOM; i++) begin
      rand_req(8'(i + 16), req);
      send(req);
    end
    wait_drain();
    bp_en       = 1'b0;
    out_ready_i = 1'b1;
    check("response count", 64'(sent), 64'(received));
    $display("Regression passed");
    $finish;
  end

endmodule

//--- bench/fp_slice_assert.sv
// Concurrent handshake and reset checks for the FP slice; bound into every fp_slice_top
`timescale 1ns/10ps

module fp_slice_assert import fp_slice_pkg::*; (
  input logic       clk_i,
  input logic       rst_i,
  input slice_rsp_t rsp_o,
  input logic       out_valid_o,
  input logic       out_ready_i,
  input logic       busy_o
);

  // A stalled response holds until the sink takes it
  property hold_until_taken;
    @(posedge clk_i) disable iff (rst_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(rsp_o);
  endproperty

  // Reset empties every stage
  property empty_after_reset;
    @(posedge clk_i) rst_i |=> !out_valid_o && !busy_o;
  endproperty

  property valid_means_busy;
    @(posedge clk_i) disable iff (rst_i) out_valid_o |-> busy_o;
  endproperty

  hold_check: assert property (hold_until_taken)
    else $error("response changed while the sink stalled");
  reset_check: assert property (empty_after_reset)
    else $error("pipeline not empty after reset");
  busy_check: assert property (valid_means_busy)
    else $error("output valid while busy is low");

endmodule

bind fp_slice_top fp_slice_assert i_assert (.*);

//--- hw/fp_slice_top.sv
// Top level of the two-lane FP slice; instantiate it with a valid/ready request and response port
`timescale 1ns/10ps
`include "slice_defs.svh"

module fp_slice_top import fp_slice_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  // Request side
  input  slice_req_t req_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  // Response side
  output slice_rsp_t rsp_o,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  // Something is in flight
  output logic       busy_o
);

  lane_stage_t                               split_stage;
  lane_stage_t                               pipe_stage;
  logic [`SLICE_LANES-1:0][`SLICE_WIDTH-1:0] lane_result;
  status_t [`SLICE_LANES-1:0]                lane_status;

  fp_slice_operand_split i_split (
    .req_i   ( req_i       ),
    .stage_o ( split_stage )
  );

  // Registers sit in front of the lanes
  fp_slice_pipe i_pipe (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .stage_i     ( split_stage ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .stage_o     ( pipe_stage  ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  for (genvar lane = 0; lane < `SLICE_LANES; lane++) begin : gen_lanes
    fp_slice_lane #(
      .LANE ( lane )
    ) i_lane (
      .operand_a_i ( pipe_stage.lane_ops[lane].operand_a ),
      .operand_b_i ( pipe_stage.lane_ops[lane].operand_b ),
      .op_i        ( pipe_stage.op                       ),
      .fmt_i       ( pipe_stage.fmt                      ),
      .result_o    ( lane_result[lane]                   ),
      .status_o    ( lane_status[lane]                   )
    );
  end

  fp_slice_result_pack i_pack (
    .lane_result_i ( lane_result            ),
    .lane_status_i ( lane_status            ),
    .lane_active_i ( pipe_stage.lane_active ),
    .simd_mask_i   ( pipe_stage.simd_mask   ),
    .fmt_i         ( pipe_stage.fmt         ),
    .tag_i         ( pipe_stage.tag         ),
    .rsp_o         ( rsp_o                  )
  );

endmodule

//--- hw/fp_slice_result_pack.sv
// Output side of the FP slice; packs lane results by format and merges the lane flags
`timescale 1ns/10ps
`include "slice_defs.svh"

module fp_slice_result_pack import fp_slice_pkg::*; (
  input  logic [`SLICE_LANES-1:0][`SLICE_WIDTH-1:0] lane_result_i,
  input  status_t [`SLICE_LANES-1:0]                lane_status_i,
  input  logic [`SLICE_LANES-1:0]                   lane_active_i,
  input  logic [`SLICE_LANES-1:0]                   simd_mask_i,
  input  fmt_e                                      fmt_i,
  input  logic [`SLICE_TAG_W-1:0]                   tag_i,
  output slice_rsp_t                                rsp_o
);

  logic [`SLICE_WIDTH-1:0] fp16_packed;
  status_t                 status_acc;

  // ------------------------------
  // FP16 slots
  // ------------------------------
  always_comb begin : pack_fp16
    for (int unsigned lane = 0; lane < `SLICE_LANES; lane++) begin
      // Idle slots are NaN-boxed
      if (lane_active_i[lane]) begin
        fp16_packed[lane*`SLICE_FP16_W +: `SLICE_FP16_W] =
            lane_result_i[lane][`SLICE_FP16_W-1:0];
      end else begin
        fp16_packed[lane*`SLICE_FP16_W +: `SLICE_FP16_W] = '1;
      end
    end
  end

  // ------------------------------
  // Status collapse
  // ------------------------------
  always_comb begin : merge_status
    status_acc = '0;
    for (int unsigned lane = 0; lane < `SLICE_LANES; lane++) begin
      // Masked or idle lanes raise nothing
      if (lane_active_i[lane] && simd_mask_i[lane]) begin
        status_acc = status_acc | lane_status_i[lane];
      end
    end
  end

  // FP32 only ever lives in lane 0
  assign rsp_o.result = (fmt_i == FMT_FP32) ? lane_result_i[0] : fp16_packed;
  assign rsp_o.status = status_acc;
  assign rsp_o.tag    = tag_i;

endmodule

//--- hw/fp_slice_lane.sv
// One SIMD lane of the FP slice; computes sign injection and min/max on its element
`timescale 1ns/10ps
`include "slice_defs.svh"

module fp_slice_lane import fp_slice_pkg::*; #(
  parameter int unsigned LANE = 0
) (
  input  logic [`SLICE_WIDTH-1:0] operand_a_i,
  input  logic [`SLICE_WIDTH-1:0] operand_b_i,
  input  op_e                     op_i,
  input  fmt_e                    fmt_i,
  output logic [`SLICE_WIDTH-1:0] result_o,
  output status_t                 status_o
);

  // Only lane 0 is wide enough for FP32
  localparam logic HAS_FP32 = (LANE == 0);

  localparam logic [`SLICE_FP32_W-1:0] QNAN_FP32 = 32'h7FC0_0000;
  localparam logic [`SLICE_FP16_W-1:0] QNAN_FP16 = 16'h7E00;

  logic                     is_fp32;
  logic                     sign_a;
  logic                     sign_b;
  logic [`SLICE_FP32_W-2:0] mag_a;
  logic [`SLICE_FP32_W-2:0] mag_b;
  logic                     nan_a;
  logic                     nan_b;
  logic                     snan_a;
  logic                     snan_b;
  logic                     a_lt_b;
  logic [`SLICE_WIDTH-1:0]  val_a;
  logic [`SLICE_WIDTH-1:0]  val_b;
  logic [`SLICE_WIDTH-1:0]  canon_nan;

  // Rebuild a value of the lane format, FP16 goes in the low half
  function automatic logic [`SLICE_WIDTH-1:0] compose(input logic                     wide,
                                                      input logic                     sign,
                                                      input logic [`SLICE_FP32_W-2:0] mag);
    if (wide) begin
      return {sign, mag};
    end
    return {{`SLICE_FP16_W{1'b1}}, sign, mag[`SLICE_FP16_W-2:0]};
  endfunction

  assign is_fp32 = HAS_FP32 && (fmt_i == FMT_FP32);

  // ------------------------------
  // Field decode
  // ------------------------------
  always_comb begin : decode
    if (is_fp32) begin
      // 1 sign, 8 exponent, 23 mantissa, quiet bit 22
      sign_a = operand_a_i[31];
      sign_b = operand_b_i[31];
      mag_a  = operand_a_i[30:0];
      mag_b  = operand_b_i[30:0];
      nan_a  = (&operand_a_i[30:23]) && (|operand_a_i[22:0]);
      nan_b  = (&operand_b_i[30:23]) && (|operand_b_i[22:0]);
      snan_a = nan_a && !operand_a_i[22];
      snan_b = nan_b && !operand_b_i[22];
    end else begin
      // 1 sign, 5 exponent, 10 mantissa, quiet bit 9
      sign_a = operand_a_i[15];
      sign_b = operand_b_i[15];
      mag_a  = {16'h0000, operand_a_i[14:0]};
      mag_b  = {16'h0000, operand_b_i[14:0]};
      nan_a  = (&operand_a_i[14:10]) && (|operand_a_i[9:0]);
      nan_b  = (&operand_b_i[14:10]) && (|operand_b_i[9:0]);
      snan_a = nan_a && !operand_a_i[9];
      snan_b = nan_b && !operand_b_i[9];
    end
  end

  // Numeric order, -0 below +0 falls out of the sign test
  always_comb begin : compare
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  assign val_a     = compose(is_fp32, sign_a, mag_a);
  assign val_b     = compose(is_fp32, sign_b, mag_b);
  assign canon_nan = is_fp32 ? QNAN_FP32 : {{`SLICE_FP16_W{1'b1}}, QNAN_FP16};

  // ------------------------------
  // Operation
  // ------------------------------
  always_comb begin : operation
    result_o = val_a;
    status_o = '0;
    case (op_i)
      OP_SGNJ:  result_o = compose(is_fp32, sign_b, mag_a);
      OP_SGNJN: result_o = compose(is_fp32, ~sign_b, mag_a);
      OP_SGNJX: result_o = compose(is_fp32, sign_a ^ sign_b, mag_a);
      OP_MIN, OP_MAX: begin
        status_o.nv = snan_a | snan_b;
        if (nan_a && nan_b) begin
          result_o = canon_nan;
        end else if (nan_a) begin
          result_o = val_b;
        end else if (nan_b) begin
          result_o = val_a;
        end else if (op_i == OP_MIN) begin
          result_o = a_lt_b ? val_a : val_b;
        end else begin
          result_o = a_lt_b ? val_b : val_a;
        end
      end
      default: result_o = val_a;
    endcase
  end

endmodule

//--- hw/fp_slice_pipe.sv
// Elastic register pipeline of the FP slice; carries the lane stage struct with valid/ready
`timescale 1ns/10ps
`include "slice_defs.svh"

module fp_slice_pipe import fp_slice_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  // Upstream
  input  lane_stage_t stage_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  // Downstream
  output lane_stage_t stage_o,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output logic        busy_o
);

  localparam int unsigned DEPTH = `SLICE_PIPE_REGS;

  lane_stage_t [DEPTH-1:0] data_q;
  logic [DEPTH-1:0]        valid_q;

  // Index i feeds stage i, index DEPTH is the pipeline output
  lane_stage_t [DEPTH:0]   data_chain;
  logic [DEPTH:0]          valid_chain;
  logic [DEPTH:0]          ready;

  assign data_chain  = {data_q, stage_i};
  assign valid_chain = {valid_q, in_valid_i};

  // ------------------------------
  // Ready propagation
  // ------------------------------
  // A stage accepts when empty or when the next one accepts
  always_comb begin : ready_chain
    ready[DEPTH] = out_ready_i;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      ready[i] = ~valid_q[i] | ready[i + 1];
    end
  end

  // ------------------------------
  // Stage registers
  // ------------------------------
  always_ff @(posedge clk_i) begin : valid_regs
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      for (int unsigned i = 0; i < DEPTH; i++) begin
        if (ready[i]) begin
          valid_q[i] <= valid_chain[i];
        end
      end
    end
  end

  // Payload only moves with a valid item
  always_ff @(posedge clk_i) begin : data_regs
    for (int unsigned i = 0; i < DEPTH; i++) begin
      if (ready[i] && valid_chain[i]) begin
        data_q[i] <= data_chain[i];
      end
    end
  end

  assign in_ready_o  = ready[0];
  assign stage_o     = data_chain[DEPTH];
  assign out_valid_o = valid_chain[DEPTH];
  assign busy_o      = |valid_q;

endmodule

//--- hw/fp_slice_operand_split.sv
// Input side of the FP slice; turns a request into per-lane operands and lane-activity bits
`timescale 1ns/10ps
`include "slice_defs.svh"

module fp_slice_operand_split import fp_slice_pkg::*; (
  input  slice_req_t  req_i,
  output lane_stage_t stage_o
);

  // Element width of the requested format
  int unsigned fmt_width;
  // Upper lanes only ever run FP16 vector work
  logic        vec_fp16;

  always_comb begin : element_width
    if (req_i.fmt == FMT_FP32) begin
      fmt_width = `SLICE_FP32_W;
    end else begin
      fmt_width = `SLICE_FP16_W;
    end
  end

  assign vec_fp16 = req_i.vectorial & (req_i.fmt == FMT_FP16);

  // ------------------------------
  // Per-lane slicing
  // ------------------------------
  always_comb begin : slice_lanes
    for (int unsigned lane = 0; lane < `SLICE_LANES; lane++) begin
      // Lane k sees its element in the low bits, upper bits ignored by the lane
      stage_o.lane_ops[lane].operand_a = req_i.operand_a >> (lane * fmt_width);
      stage_o.lane_ops[lane].operand_b = req_i.operand_b >> (lane * fmt_width);
      if (lane == 0) begin
        stage_o.lane_active[lane] = 1'b1;
      end else begin
        stage_o.lane_active[lane] = vec_fp16;
      end
    end
  end

  // Control fields travel unchanged
  assign stage_o.simd_mask = req_i.simd_mask;
  assign stage_o.op        = req_i.op;
  assign stage_o.fmt       = req_i.fmt;
  assign stage_o.tag       = req_i.tag;

endmodule

//--- hw/fp_slice_pkg.sv
// Shared types of the FP slice; import into any module that moves requests, stages or responses
`include "slice_defs.svh"

package fp_slice_pkg;

  // Supported floating-point formats
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fmt_e;

  // Non-computational operations
  typedef enum logic [2:0] {
    OP_SGNJ  = 3'd0,
    OP_SGNJN = 3'd1,
    OP_SGNJX = 3'd2,
    OP_MIN   = 3'd3,
    OP_MAX   = 3'd4
  } op_e;

  // IEEE exception flags, invalid first
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // Request as seen at the slice boundary
  typedef struct packed {
    logic [`SLICE_WIDTH-1:0] operand_a;
    logic [`SLICE_WIDTH-1:0] operand_b;
    op_e                     op;
    fmt_e                    fmt;
    logic                    vectorial;
    logic [`SLICE_LANES-1:0] simd_mask;
    logic [`SLICE_TAG_W-1:0] tag;
  } slice_req_t;

  // Operand pair of a single lane
  typedef struct packed {
    logic [`SLICE_WIDTH-1:0] operand_a;
    logic [`SLICE_WIDTH-1:0] operand_b;
  } lane_ops_t;

  // Pipeline payload, operands already split per lane
  typedef struct packed {
    lane_ops_t [`SLICE_LANES-1:0] lane_ops;
    logic [`SLICE_LANES-1:0]      lane_active;
    logic [`SLICE_LANES-1:0]      simd_mask;
    op_e                          op;
    fmt_e                         fmt;
    logic [`SLICE_TAG_W-1:0]      tag;
  } lane_stage_t;

  // Response returned to the sink
  typedef struct packed {
    logic [`SLICE_WIDTH-1:0] result;
    status_t                 status;
    logic [`SLICE_TAG_W-1:0] tag;
  } slice_rsp_t;

endpackage

//--- include/slice_defs.svh
// Sizing macros for the FP slice; include wherever a width, lane count or depth is needed
`ifndef SLICE_DEFS_SVH
`define SLICE_DEFS_SVH

// ------------------------------
// Data path
// ------------------------------
`define SLICE_WIDTH 32
`define SLICE_LANES 2

// Floating-point format widths
`define SLICE_FP32_W 32
`define SLICE_FP16_W 16

// ------------------------------
// Pipeline
// ------------------------------
// Number of register stages between request and lanes
`define SLICE_PIPE_REGS 2

// Width of the tag carried along with each request
`define SLICE_TAG_W 8

`endif
